// ==== design/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // Core sizes
    localparam int xlen = 32;
    localparam int num_regs = 32;
    localparam int rob_depth = 7;
    localparam int tag_w = 3;
    localparam int num_stations = 3;

    // ALU operations carried to the stations
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    // RV32I opcodes of the supported subset
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // Only bit 30 separates sub from add
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    // One instruction word, read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
    } instr_u;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,

    // Dispatch read ports
    input wire logic [4:0] rs1,
    input wire logic [4:0] rs2,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value,
    output logic [tag_w-1:0] rs1_tag,
    output logic [tag_w-1:0] rs2_tag,

    // Rename from dispatch
    input wire logic rename_we,
    input wire logic [4:0] rename_rd,
    input wire logic [tag_w-1:0] rename_tag,

    // Commit from the ROB
    input wire logic commit_valid,
    input wire logic [4:0] commit_rd,
    input wire logic [tag_w-1:0] commit_tag,
    input wire logic [xlen-1:0] commit_value
);

    logic [xlen-1:0] regs [num_regs];
    logic [tag_w-1:0] tags [num_regs];

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign rs1_tag = tags[rs1];
    assign rs2_tag = tags[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // x0 stays zero even though its writes commit
            if (commit_valid && commit_rd != 5'd0) begin
                regs[commit_rd] <= commit_value;
                // A younger producer keeps its tag
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= '0;
                end
            end
            // Later assignment, so rename wins the tag
            if (rename_we && rename_rd != 5'd0) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dispatch_unit.sv ====
`default_nettype none

module dispatch_unit
    import ooo_pkg::*;
(
    input wire logic inst_valid,
    input wire logic [31:0] inst_word,
    output logic inst_ready,

    // Register file
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    input wire logic [xlen-1:0] rs1_value,
    input wire logic [xlen-1:0] rs2_value,
    input wire logic [tag_w-1:0] rs1_tag,
    input wire logic [tag_w-1:0] rs2_tag,
    output logic rename_we,
    output logic [4:0] rename_rd,
    output logic [tag_w-1:0] rename_tag,

    // Reorder buffer
    output logic alloc,
    output logic [4:0] alloc_rd,
    input wire logic [tag_w-1:0] alloc_tag,
    input wire logic full,
    output logic [tag_w-1:0] src1_tag,
    output logic [tag_w-1:0] src2_tag,
    input wire logic src1_done,
    input wire logic [xlen-1:0] src1_value,
    input wire logic src2_done,
    input wire logic [xlen-1:0] src2_value,

    // CDB bypass
    input wire logic cdb_valid,
    input wire logic [tag_w-1:0] cdb_tag,
    input wire logic [xlen-1:0] cdb_value,

    // Reservation stations
    input wire logic [num_stations-1:0] busy,
    output logic [num_stations-1:0] load,
    output alu_op_t op,
    output logic [tag_w-1:0] dest_tag,
    output logic [xlen-1:0] v1,
    output logic [tag_w-1:0] t1,
    output logic [xlen-1:0] v2,
    output logic [tag_w-1:0] t2
);

    instr_u iw;
    logic is_reg;
    logic accept;
    logic [num_stations-1:0] free_sel;
    logic [xlen-1:0] imm;
    logic [tag_w+xlen-1:0] opnd1;
    logic [tag_w+xlen-1:0] opnd2;

    // Register, then ROB, then CDB, else wait on the tag
    function automatic logic [tag_w+xlen-1:0] resolve(
        input logic [tag_w-1:0] rtag,
        input logic [xlen-1:0] rval,
        input logic rob_done,
        input logic [xlen-1:0] rob_val,
        input logic bus_valid,
        input logic [tag_w-1:0] bus_tag,
        input logic [xlen-1:0] bus_val
    );
        if (rtag == '0) begin
            return {{tag_w{1'b0}}, rval};
        end else if (rob_done) begin
            return {{tag_w{1'b0}}, rob_val};
        end else if (bus_valid && bus_tag == rtag) begin
            return {{tag_w{1'b0}}, bus_val};
        end
        return {rtag, {xlen{1'b0}}};
    endfunction

    assign iw = inst_word;
    assign is_reg = (iw.r.opcode == op_reg);
    assign imm = {{(xlen-12){iw.i.imm12[11]}}, iw.i.imm12};

    assign rs1 = iw.r.rs1;
    assign rs2 = is_reg ? iw.r.rs2 : 5'd0;
    assign src1_tag = rs1_tag;
    assign src2_tag = rs2_tag;

    // Lowest clear bit of busy
    assign free_sel = ~busy & (busy + 1'b1);
    assign inst_ready = !full && (|(~busy));
    assign accept = inst_valid && inst_ready;

    assign load = accept ? free_sel : '0;
    assign alloc = accept;
    assign alloc_rd = iw.i.rd;
    assign dest_tag = alloc_tag;
    assign rename_we = accept && (iw.i.rd != 5'd0);
    assign rename_rd = iw.i.rd;
    assign rename_tag = alloc_tag;

    always_comb begin
        case (iw.r.funct3)
            f3_add_sub: op = (is_reg && iw.r.funct7 == f7_alt) ? alu_sub : alu_add;
            f3_slt: op = alu_slt;
            f3_xor: op = alu_xor;
            f3_or: op = alu_or;
            f3_and: op = alu_and;
            default: op = alu_add;
        endcase
    end

    assign opnd1 = resolve(rs1_tag, rs1_value, src1_done, src1_value,
                           cdb_valid, cdb_tag, cdb_value);
    assign opnd2 = is_reg ? resolve(rs2_tag, rs2_value, src2_done, src2_value,
                                    cdb_valid, cdb_tag, cdb_value)
                          : {{tag_w{1'b0}}, imm};
    assign {t1, v1} = opnd1;
    assign {t2, v2} = opnd2;

endmodule

`default_nettype wire

// ==== design/alu_station.sv ====
`default_nettype none

module alu_station
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic load,
    input wire alu_op_t op,
    input wire logic [tag_w-1:0] dest_tag,
    input wire logic [xlen-1:0] v1,
    input wire logic [tag_w-1:0] t1,
    input wire logic [xlen-1:0] v2,
    input wire logic [tag_w-1:0] t2,
    input wire logic cdb_valid,
    input wire logic [tag_w-1:0] cdb_tag,
    input wire logic [xlen-1:0] cdb_value,
    input wire logic grant,
    output logic busy,
    output logic req,
    output logic [xlen-1:0] result,
    output logic [tag_w-1:0] result_tag
);

    alu_op_t op_q;
    logic [tag_w-1:0] dest_q;
    logic [xlen-1:0] v1_q, v2_q;
    logic [tag_w-1:0] t1_q, t2_q;
    logic hit1, hit2;
    logic [xlen-1:0] e1, e2;
    logic ready;

    function automatic logic [xlen-1:0] alu(input alu_op_t f, input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
        case (f)
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or: return a | b;
            alu_xor: return a ^ b;
            alu_slt: return ($signed(a) < $signed(b)) ? xlen'(1) : xlen'(0);
            default: return a + b;
        endcase
    endfunction

    // Operands as they stand after this cycle's broadcast
    assign hit1 = busy && cdb_valid && t1_q != '0 && cdb_tag == t1_q;
    assign hit2 = busy && cdb_valid && t2_q != '0 && cdb_tag == t2_q;
    assign e1 = hit1 ? cdb_value : v1_q;
    assign e2 = hit2 ? cdb_value : v2_q;
    assign ready = busy && !req && (hit1 || t1_q == '0) && (hit2 || t2_q == '0);

    assign result_tag = dest_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            req <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
            req <= 1'b0;
        end else if (req && grant) begin
            // Freed as the arbiter registers the broadcast
            busy <= 1'b0;
            req <= 1'b0;
        end else if (ready) begin
            req <= 1'b1;
        end
    end

    // Held operation, operands and result
    always_ff @(posedge clk) begin
        if (load) begin
            op_q <= op;
            dest_q <= dest_tag;
            v1_q <= v1;
            t1_q <= t1;
            v2_q <= v2;
            t2_q <= t2;
        end else begin
            if (hit1) begin
                v1_q <= cdb_value;
                t1_q <= '0;
            end
            if (hit2) begin
                v2_q <= cdb_value;
                t2_q <= '0;
            end
            if (ready) begin
                result <= alu(op_q, e1, e2);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic [num_stations-1:0] req,
    input wire logic [num_stations*xlen-1:0] result,
    input wire logic [num_stations*tag_w-1:0] result_tag,
    output logic [num_stations-1:0] grant,
    output logic cdb_valid,
    output logic [tag_w-1:0] cdb_tag,
    output logic [xlen-1:0] cdb_value
);

    logic [xlen-1:0] sel_value;
    logic [tag_w-1:0] sel_tag;

    // Lowest index wins
    assign grant = req & (~req + 1'b1);

    always_comb begin
        sel_value = '0;
        sel_tag = '0;
        for (int s = 0; s < num_stations; s++) begin
            if (grant[s]) begin
                sel_value = result[s*xlen +: xlen];
                sel_tag = result_tag[s*tag_w +: tag_w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |req;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag <= sel_tag;
        cdb_value <= sel_value;
    end

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic alloc,
    input wire logic [4:0] alloc_rd,
    output logic [tag_w-1:0] alloc_tag,
    output logic full,
    input wire logic [tag_w-1:0] src1_tag,
    input wire logic [tag_w-1:0] src2_tag,
    output logic src1_done,
    output logic [xlen-1:0] src1_value,
    output logic src2_done,
    output logic [xlen-1:0] src2_value,
    input wire logic cdb_valid,
    input wire logic [tag_w-1:0] cdb_tag,
    input wire logic [xlen-1:0] cdb_value,
    output logic commit_valid,
    output logic [4:0] commit_rd,
    output logic [tag_w-1:0] commit_tag,
    output logic [xlen-1:0] commit_value
);

    // Entry 0 is never allocated and reads back as not done
    logic e_valid [rob_depth+1];
    logic e_done [rob_depth+1];
    logic [4:0] e_rd [rob_depth+1];
    logic [xlen-1:0] e_value [rob_depth+1];

    logic [tag_w-1:0] head, tail;
    logic [$clog2(rob_depth+1)-1:0] count;
    logic do_alloc, do_commit;

    function automatic logic [tag_w-1:0] next_tag(input logic [tag_w-1:0] t);
        return (t == tag_w'(rob_depth)) ? tag_w'(1) : t + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign full = (count == rob_depth);
    assign do_alloc = alloc && !full;
    assign do_commit = e_valid[head] && e_done[head];

    // Done and value stay readable after commit until reallocation
    assign src1_done = e_done[src1_tag];
    assign src1_value = e_value[src1_tag];
    assign src2_done = e_done[src2_tag];
    assign src2_value = e_value[src2_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= tag_w'(1);
            tail <= tag_w'(1);
            count <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i <= rob_depth; i++) begin
                e_valid[i] <= 1'b0;
                e_done[i] <= 1'b0;
            end
        end else begin
            commit_valid <= do_commit;
            if (cdb_valid) begin
                e_done[cdb_tag] <= 1'b1;
            end
            if (do_commit) begin
                e_valid[head] <= 1'b0;
                head <= next_tag(head);
            end
            if (do_alloc) begin
                e_valid[tail] <= 1'b1;
                e_done[tail] <= 1'b0;
                tail <= next_tag(tail);
            end
            case ({do_alloc, do_commit})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            e_value[cdb_tag] <= cdb_value;
        end
        if (do_alloc) begin
            e_rd[tail] <= alloc_rd;
        end
        commit_rd <= e_rd[head];
        commit_tag <= head;
        commit_value <= e_value[head];
    end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
`default_nettype none

module ooo_core
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic inst_valid,
    input wire logic [31:0] inst_word,
    output logic inst_ready,
    output logic commit_valid,
    output logic [4:0] commit_rd,
    output logic [xlen-1:0] commit_value
);

    logic [4:0] rs1, rs2, rename_rd, alloc_rd;
    logic [xlen-1:0] rs1_value, rs2_value, src1_value, src2_value;
    logic [tag_w-1:0] rs1_tag, rs2_tag, rename_tag, alloc_tag, src1_tag, src2_tag;
    logic rename_we, alloc, full, src1_done, src2_done;
    logic cdb_valid;
    logic [tag_w-1:0] cdb_tag, commit_tag;
    logic [xlen-1:0] cdb_value;

    // Station side
    logic [num_stations-1:0] busy, load, req, grant;
    alu_op_t op;
    logic [tag_w-1:0] dest_tag, t1, t2;
    logic [xlen-1:0] v1, v2;
    logic [num_stations*xlen-1:0] result;
    logic [num_stations*tag_w-1:0] result_tag;

    reg_file i_reg_file (
        .clk, .rst_n, .rs1, .rs2, .rs1_value, .rs2_value, .rs1_tag, .rs2_tag,
        .rename_we, .rename_rd, .rename_tag,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    dispatch_unit i_dispatch (
        .inst_valid, .inst_word, .inst_ready,
        .rs1, .rs2, .rs1_value, .rs2_value, .rs1_tag, .rs2_tag,
        .rename_we, .rename_rd, .rename_tag,
        .alloc, .alloc_rd, .alloc_tag, .full,
        .src1_tag, .src2_tag, .src1_done, .src1_value, .src2_done, .src2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .busy, .load, .op, .dest_tag, .v1, .t1, .v2, .t2
    );

    reorder_buffer i_rob (
        .clk, .rst_n, .alloc, .alloc_rd, .alloc_tag, .full,
        .src1_tag, .src2_tag, .src1_done, .src1_value, .src2_done, .src2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    cdb_arbiter i_arbiter (
        .clk, .rst_n, .req, .result, .result_tag, .grant,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    for (genvar s = 0; s < num_stations; s++) begin : g_station
        alu_station i_station (
            .clk, .rst_n, .load(load[s]), .op, .dest_tag, .v1, .t1, .v2, .t2,
            .cdb_valid, .cdb_tag, .cdb_value, .grant(grant[s]),
            .busy(busy[s]), .req(req[s]),
            .result(result[s*xlen +: xlen]),
            .result_tag(result_tag[s*tag_w +: tag_w])
        );
    end

endmodule

`default_nettype wire

// ==== test/ooo_core_assert.sv ====
`default_nettype none

module ooo_core_assert
    import ooo_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic inst_valid,
    input wire logic [31:0] inst_word,
    input wire logic inst_ready,
    input wire logic commit_valid,
    input wire logic [4:0] commit_rd,
    input wire logic [xlen-1:0] commit_value
);
    timeunit 1ns;
    timeprecision 1ps;

    // In-order shadow registers and the queue of expected commits
    logic [xlen-1:0] shadow [num_regs];
    logic [4:0] exp_rd [16];
    logic [xlen-1:0] exp_value [16];
    logic [3:0] wr_ptr, rd_ptr, pending;
    logic [4:0] head_rd;
    logic [xlen-1:0] head_value, opnd_a, opnd_b, next_value;
    instr_u iw;
    int assert_errors = 0;

    function automatic logic [xlen-1:0] model_alu(input instr_u w, input logic [xlen-1:0] x,
                                                  input logic [xlen-1:0] y);
        logic reg_form;
        reg_form = (w.r.opcode == op_reg);
        case (w.r.funct3)
            f3_add_sub: return (reg_form && w.r.funct7 == f7_alt) ? x - y : x + y;
            f3_slt: return {{(xlen-1){1'b0}}, $signed(x) < $signed(y)};
            f3_xor: return x ^ y;
            f3_or: return x | y;
            f3_and: return x & y;
            default: return x + y;
        endcase
    endfunction

    assign iw = inst_word;
    assign opnd_a = shadow[iw.r.rs1];
    assign opnd_b = (iw.r.opcode == op_reg) ? shadow[iw.r.rs2]
                                            : {{(xlen-12){iw.i.imm12[11]}}, iw.i.imm12};
    assign next_value = model_alu(iw, opnd_a, opnd_b);
    assign pending = wr_ptr - rd_ptr;
    assign head_rd = exp_rd[rd_ptr];
    assign head_value = exp_value[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            for (int i = 0; i < num_regs; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (inst_valid && inst_ready) begin
                exp_rd[wr_ptr] <= iw.i.rd;
                exp_value[wr_ptr] <= next_value;
                wr_ptr <= wr_ptr + 1'b1;
                // x0 keeps reading as zero
                if (iw.i.rd != 5'd0) begin
                    shadow[iw.i.rd] <= next_value;
                end
            end
            if (commit_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !commit_valid && inst_ready)
        else begin
            assert_errors++;
            $error("FAIL commit_valid %h inst_ready %h after reset",
                   $sampled(commit_valid), $sampled(inst_ready));
        end

    a_commit_known: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> pending != 4'd0)
        else begin
            assert_errors++;
            $error("FAIL commit_valid %h with no accepted instruction", $sampled(commit_valid));
        end

    a_commit_rd: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit_rd == head_rd)
        else begin
            assert_errors++;
            $error("FAIL commit_rd: expected %h, got %h", $sampled(head_rd), $sampled(commit_rd));
        end

    a_commit_value: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit_value == head_value)
        else begin
            assert_errors++;
            $error("FAIL commit_value: expected %h, got %h",
                   $sampled(head_value), $sampled(commit_value));
        end

    // Seven in flight with no commit on the way means a full ROB
    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        pending == 4'(rob_depth) && !commit_valid |-> !inst_ready)
        else begin
            assert_errors++;
            $error("FAIL inst_ready: expected 0, got %h with %h in flight",
                   $sampled(inst_ready), $sampled(pending));
        end

    a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        pending <= 4'(rob_depth))
        else begin
            assert_errors++;
            $error("FAIL pending: limit %h, got %h", rob_depth, $sampled(pending));
        end

endmodule

bind ooo_core ooo_core_assert i_assert (.*);

`default_nettype wire

// ==== test/tb_ooo_core.sv ====
`default_nettype none

module tb_ooo_core
    import ooo_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_directed = 24;
    localparam int n_random = 200;
    localparam int reset_cycles = 5;
    localparam int limit_cycles = (n_directed + n_random) * 30 + reset_cycles;

    logic clk = 1'b0;
    logic rst_n;
    logic inst_valid;
    logic [31:0] inst_word;
    logic inst_ready;
    logic commit_valid;
    logic [4:0] commit_rd;
    logic [xlen-1:0] commit_value;

    integer seed = 48;
    int issued = 0;
    int committed = 0;
    int timeouts = 0;

    ooo_core i_dut (
        .clk, .rst_n, .inst_valid, .inst_word, .inst_ready,
        .commit_valid, .commit_rd, .commit_value
    );

    always #20 clk = ~clk;

    // Commit outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            committed++;
        end
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    // Only x0 to x3, so dependencies are frequent
    function automatic logic [31:0] random_inst();
        logic [4:0] rd, rs1, rs2;
        logic [11:0] imm;
        logic reg_form;
        logic [2:0] f3;
        int pick;
        rd = 5'($unsigned($random(seed)) % 4);
        rs1 = 5'($unsigned($random(seed)) % 4);
        rs2 = 5'($unsigned($random(seed)) % 4);
        imm = 12'($random(seed));
        reg_form = 1'($random(seed));
        pick = int'($unsigned($random(seed)) % 6);
        case (pick)
            2: f3 = f3_and;
            3: f3 = f3_or;
            4: f3 = f3_xor;
            5: f3 = f3_slt;
            default: f3 = f3_add_sub;
        endcase
        if (reg_form) begin
            return r_word((pick == 1) ? f7_alt : f7_base, f3, rd, rs1, rs2);
        end
        return i_word(f3, rd, rs1, imm);
    endfunction

    // Word stays valid until inst_ready is seen with it
    task automatic issue(input logic [31:0] word);
        @(negedge clk);
        inst_valid = 1'b1;
        inst_word = word;
        while (!inst_ready) begin
            @(negedge clk);
        end
        issued++;
    endtask

    task automatic report();
        int assert_errors;
        assert_errors = i_dut.i_assert.assert_errors;
        if (committed != issued) begin
            $display("FAIL committed: expected %h, got %h", issued, committed);
        end
        $display("issued %0d, committed %0d, timeout errors %0d, assertion errors %0d",
                 issued, committed, timeouts, assert_errors);
        if (assert_errors == 0 && timeouts == 0 && committed == issued) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst_word = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Dependency chain over every op in both forms
        issue(i_word(f3_add_sub, 5'd1, 5'd0, 12'd5));
        issue(i_word(f3_add_sub, 5'd2, 5'd1, 12'hffd));
        issue(r_word(f7_base, f3_add_sub, 5'd3, 5'd1, 5'd2));
        issue(r_word(f7_alt, f3_add_sub, 5'd4, 5'd3, 5'd1));
        issue(r_word(f7_base, f3_slt, 5'd5, 5'd2, 5'd4));
        issue(r_word(f7_base, f3_xor, 5'd6, 5'd5, 5'd3));
        issue(r_word(f7_base, f3_or, 5'd7, 5'd6, 5'd1));
        issue(r_word(f7_base, f3_and, 5'd8, 5'd7, 5'd3));
        issue(i_word(f3_slt, 5'd9, 5'd2, 12'hfff));
        issue(i_word(f3_xor, 5'd10, 5'd9, 12'h0f0));
        issue(i_word(f3_or, 5'd11, 5'd10, 12'h123));
        issue(i_word(f3_and, 5'd12, 5'd11, 12'h0ff));
        // Write to x0, then read it back
        issue(i_word(f3_add_sub, 5'd0, 5'd1, 12'd7));
        issue(r_word(f7_base, f3_add_sub, 5'd13, 5'd0, 5'd1));
        issue(r_word(f7_alt, f3_add_sub, 5'd1, 5'd1, 5'd1));
        issue(r_word(f7_base, f3_add_sub, 5'd2, 5'd1, 5'd0));
        // Independent burst toward a full ROB
        for (int k = 0; k < 8; k++) begin
            issue(i_word(f3_add_sub, 5'd15, 5'd0, 12'(k + 1)));
        end
        for (int k = 0; k < n_random; k++) begin
            issue(random_inst());
        end
        @(negedge clk);
        inst_valid = 1'b0;
        wait (committed == issued);
        repeat (4) @(posedge clk);
        report();
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: commits did not finish");
        timeouts++;
        report();
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/ooo_pkg.sv
design/reg_file.sv
design/dispatch_unit.sv
design/alu_station.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/ooo_core_assert.sv
test/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert -f list.f --top-module tb_ooo_core -o sim_ooo_core || exit 1
./obj_dir/sim_ooo_core > sim.log 2>&1
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
